// File: aesControl.sv
`timescale 1ns/1ns

module aesControl import aesTypesPkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	output logic busy,
	output logic done,
	keyIf.ctrl keys
);

	logic [RoundCountWidth-1:0] round; // Round applied at the next step edge

	// A start is only taken while idle, a start during a run is dropped
	assign keys.load = start & ~busy;

	// Every busy cycle is a round cycle, there is no stall
	assign keys.step = busy;

	assign keys.lastRound = busy && (round == RoundCountWidth'(NumRounds));

	// ------------------------------------------------------------------------
	// Sequencing
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			round <= '0;
		end else begin
			done <= keys.lastRound; // Pulses after the edge that stores round ten

			if (keys.load) begin
				busy <= 1'b1;
				round <= RoundCountWidth'(1);
			end else if (keys.lastRound) begin
				busy <= 1'b0;       // Idle again in the same cycle done is high
			end else if (keys.step) begin
				round <= round + 1'b1;
			end
		end
	end

endmodule

// File: aesCore.sv
`timescale 1ns/1ns

module aesCore import aesTypesPkg::*; (
	input logic clk,
	input logic rst,
	input logic start,
	input block_t plainText,
	input block_t cipherKey,
	output block_t cipherText,
	output logic done,
	output logic busy
);

	keyIf keys_i ();

	aesControl aesControl_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.done(done),
		.keys(keys_i)
	);

	// Key schedule runs in lockstep with the datapath, one key per round
	aesKeySchedule aesKeySchedule_i (
		.clk(clk),
		.rst(rst),
		.cipherKey(cipherKey),
		.keys(keys_i)
	);

	aesRoundDatapath aesRoundDatapath_i (
		.clk(clk),
		.rst(rst),
		.plainText(plainText),
		.keys(keys_i),
		.cipherText(cipherText)
	);

endmodule

// File: aesCoreTb.sv
`timescale 1ns/1ns

module aesCoreTb import aesTypesPkg::*; ();

	localparam int ResetCycles = 16;
	localparam int MaxOps = 8;
	localparam int MaxOpCycles = 15;  // Twelve cycles of a run plus the longest idle gap
	localparam int WatchdogCycles = ResetCycles + MaxOps * MaxOpCycles + 264;

	// Published known-answer vectors
	localparam block_t KeyB = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam block_t PtB = 128'h3243f6a8885a308d313198a2e0370734;
	localparam block_t CtB = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam block_t KeyC = 128'h000102030405060708090a0b0c0d0e0f;
	localparam block_t PtC = 128'h00112233445566778899aabbccddeeff;
	localparam block_t CtC = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam block_t CtZero = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

	logic clk;
	logic rst;
	logic start;
	block_t plainText;
	block_t cipherKey;
	block_t cipherText;
	logic done;
	logic busy;

	aesCore aesCore_i (
		.clk(clk),
		.rst(rst),
		.start(start),
		.plainText(plainText),
		.cipherKey(cipherKey),
		.cipherText(cipherText),
		.done(done),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------

	task automatic checkResult(input string name, input block_t expected);
		assert (cipherText === expected) else begin
			$display("FAIL %s: expected %h actual %h", name, expected, cipherText);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	// Returns at the falling edge of the cycle in which done is high
	task automatic runOp(input string name, input block_t key, input block_t pt,
		input block_t expected, input bit stray);
		int strayAt;
		int cyc;
		cipherKey = key;
		plainText = pt;
		start = 1'b1;
		@(negedge clk);
		strayAt = $urandom % 9; // Any of these cycles is inside the busy window
		cyc = 0;
		while (!done) begin
			start = stray && (cyc == strayAt);
			if (start) begin
				cipherKey = ~key;   // Other operands, which must be ignored
				plainText = ~pt;
			end
			@(negedge clk);
			cyc++;
		end
		start = 1'b0;
		checkResult(name, expected);
	endtask

	task automatic idleGap();
		repeat ($urandom % 4) @(negedge clk);
	endtask

	// A failed timing assertion ends the run at once
	initial begin
		wait (aesCore_i.aesCoreAsserts_i.errorCount != 0);
		$display("A timing assertion on the core failed");
		$display("FAIL: see errors above");
		$fatal(1);
	end

	initial begin
		repeat (WatchdogCycles) @(posedge clk);
		$display("Timeout, the tests did not finish within %0d cycles", WatchdogCycles);
		$display("FAIL: see errors above");
		$fatal(1);
	end

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	initial begin
		void'($urandom(27301));
		rst = 1'b1;
		start = 1'b0;
		plainText = '0;
		cipherKey = '0;
		repeat (ResetCycles) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		assert (!done && !busy) else begin
			$display("FAIL reset: expected done 0 busy 0 actual done %b busy %b", done, busy);
			$display("FAIL: see errors above");
			$fatal(1);
		end

		runOp("fips197 appendix B", KeyB, PtB, CtB, 1'b0);
		idleGap();
		runOp("fips197 appendix C.1", KeyC, PtC, CtC, 1'b0);
		idleGap();
		runOp("all-zero key and block", '0, '0, CtZero, 1'b0);
		idleGap();
		runOp("stray start while busy", KeyB, PtB, CtB, 1'b1);
		idleGap();

		// Second start goes out in the cycle where the first done is high
		runOp("back-to-back first", KeyC, PtC, CtC, 1'b0);
		runOp("back-to-back second", '0, '0, CtZero, 1'b0);

		repeat (6) begin
			@(negedge clk);
			checkResult("hold after done", CtZero);
		end

		runOp("stray start again", KeyC, PtC, CtC, 1'b1);
		repeat (2) @(negedge clk);

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: aesCore_asserts.sv
`timescale 1ns/1ns

// Timing checks on the core ports, bound into every aesCore instance
module aesCoreAsserts (
	input logic clk,
	input logic rst,
	input logic start,
	input logic busy,
	input logic done
);

	int errorCount = 0; // Number of failed timing assertions

	// ------------------------------------------------------------------------
	// Control timing
	// ------------------------------------------------------------------------

	// Both status outputs come out of reset low
	resetIdle: assert property (@(posedge clk) rst |=> (!done && !busy))
		else begin
			$error("done or busy is high right after reset");
			errorCount++;
		end

	// An accepted start runs ten busy cycles, then done with busy already low
	fixedLatency: assert property (@(posedge clk) disable iff (rst)
		(start && !busy) |=> (busy && !done) [*10] ##1 (done && !busy))
		else begin
			$error("done did not follow an accepted start after exactly 11 edges");
			errorCount++;
		end

	donePulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else begin
			$error("done stayed high for more than one cycle");
			errorCount++;
		end

	doneNotBusy: assert property (@(posedge clk) disable iff (rst) !(done && busy))
		else begin
			$error("done and busy were high in the same cycle");
			errorCount++;
		end

endmodule

bind aesCore aesCoreAsserts aesCoreAsserts_i (
	.clk(clk),
	.rst(rst),
	.start(start),
	.busy(busy),
	.done(done)
);

// File: aesGfPkg.sv
package aesGfPkg;

	import aesTypesPkg::*;

	localparam byte_t RconInit = 8'h01; // Round constant of the first expansion step

	// ------------------------------------------------------------------------
	// GF(2^8) arithmetic with the polynomial x^8 + x^4 + x^3 + x + 1
	// ------------------------------------------------------------------------

	// Multiply by x, folding the carry back with the low part of the polynomial
	function automatic byte_t xtime(byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// Shift-and-add multiply, one xtime per bit of b
	function automatic byte_t gfMul(byte_t a, byte_t b);
		byte_t acc;
		byte_t p;
		acc = '0;
		p = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				acc ^= p;
			p = xtime(p);
		end
		return acc;
	endfunction

	// a^254 equals a^-1 for nonzero a, and zero stays zero
	// 254 = 2 + 4 + ... + 128, so collect the repeated squares
	function automatic byte_t gfInverse(byte_t a);
		byte_t sq;
		byte_t acc;
		sq = a;
		acc = 8'h01;
		for (int i = 1; i < 8; i++) begin
			sq = gfMul(sq, sq);   // Now a^(2^i)
			acc = gfMul(acc, sq);
		end
		return acc;
	endfunction

	// Forward S-box, the field inverse followed by the affine map
	function automatic byte_t sBox(byte_t a);
		byte_t inv;
		inv = gfInverse(a);
		return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
			{inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
	endfunction

endpackage

// File: aesKeySchedule.sv
`timescale 1ns/1ns

module aesKeySchedule import aesTypesPkg::*, aesGfPkg::*; (
	input logic clk,
	input logic rst,
	input block_t cipherKey,
	keyIf.sched keys
);

	word_t [0:3] keyReg;   // Key presented at the last load or step
	word_t [0:3] nextKey;
	byte_t rcon;           // Constant for the next expansion step
	word_t rotSub;

	// ------------------------------------------------------------------------
	// Next round key from the stored one
	// ------------------------------------------------------------------------

	always_comb begin
		word_t last;
		last = keyReg[3];

		// RotWord then SubWord on the last word
		rotSub[0] = sBox(last[1]) ^ rcon; // Rcon only touches the top byte
		rotSub[1] = sBox(last[2]);
		rotSub[2] = sBox(last[3]);
		rotSub[3] = sBox(last[0]);

		// Each new word depends on the one just made
		nextKey[0] = keyReg[0] ^ rotSub;
		nextKey[1] = keyReg[1] ^ nextKey[0];
		nextKey[2] = keyReg[2] ^ nextKey[1];
		nextKey[3] = keyReg[3] ^ nextKey[2];
	end

	// The cipher key goes straight out for the initial key addition
	assign keys.roundKey = keys.load ? cipherKey : nextKey;

	// ------------------------------------------------------------------------
	// Key and round-constant registers
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			keyReg <= '0;
			rcon <= RconInit;
		end else if (keys.load) begin
			keyReg <= cipherKey;
			rcon <= RconInit;
		end else if (keys.step) begin
			keyReg <= nextKey;
			rcon <= xtime(rcon);  // 01, 02, 04 ... 80, 1b, 36
		end
	end

endmodule

// File: aesMixColumns.sv
`timescale 1ns/1ns

// Forward MixColumns, each column times the circulant matrix
//   02 03 01 01
//   01 02 03 01
//   01 01 02 03
//   03 01 01 02
module aesMixColumns import aesTypesPkg::*, aesGfPkg::*; (
	input aesState_t stateIn,
	output aesState_t stateOut
);

	always_comb begin
		word_t col;
		word_t dbl;

		for (int c = 0; c < 4; c++) begin
			col = stateIn.cols[c];

			// Each byte doubled once, times three is then the double XOR the byte
			for (int r = 0; r < 4; r++) begin
				dbl[r] = xtime(col[r]);
			end

			// Row r gets 2*a[r] + 3*a[r+1] + a[r+2] + a[r+3], indices mod 4
			for (int r = 0; r < 4; r++) begin
				stateOut.cols[c][r] = dbl[r] ^
					dbl[(r + 1) % 4] ^ col[(r + 1) % 4] ^
					col[(r + 2) % 4] ^
					col[(r + 3) % 4];
			end
		end
	end

endmodule

// File: aesRoundDatapath.sv
`timescale 1ns/1ns

module aesRoundDatapath import aesTypesPkg::*, aesGfPkg::*; (
	input logic clk,
	input logic rst,
	input block_t plainText,
	keyIf.dp keys,
	output block_t cipherText
);

	aesState_t stateReg;
	aesState_t subbed;
	aesState_t shifted;
	aesState_t mixed;
	aesState_t roundOut;

	// ------------------------------------------------------------------------
	// SubBytes and ShiftRows
	// ------------------------------------------------------------------------

	always_comb begin
		for (int i = 0; i < 16; i++) begin
			subbed.bytes[i] = sBox(stateReg.bytes[i]);
		end
	end

	// Row r rotates left by r columns
	// Output byte at column c takes the byte from column c + r of the same row
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted.bytes[4 * c + r] = subbed.bytes[4 * ((c + r) % 4) + r];
			end
		end
	end

	aesMixColumns aesMixColumns_i (
		.stateIn(shifted),
		.stateOut(mixed)
	);

	// The final round leaves out the column mixing
	assign roundOut = (keys.lastRound ? shifted : mixed) ^ keys.roundKey;

	// ------------------------------------------------------------------------
	// State register
	// ------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			stateReg <= '0;
		end else if (keys.load) begin
			stateReg <= plainText ^ keys.roundKey; // Initial AddRoundKey
		end else if (keys.step) begin
			stateReg <= roundOut;
		end
	end

	// Holds the result until the next accepted start
	assign cipherText = stateReg;

endmodule

// File: aesTypesPkg.sv
package aesTypesPkg;

	// ------------------------------------------------------------------------
	// Cipher dimensions
	// ------------------------------------------------------------------------

	localparam int NumRounds = 10;       // AES-128 always runs ten rounds
	localparam int RoundCountWidth = 4;  // Wide enough to count up to NumRounds

	// ------------------------------------------------------------------------
	// Data types
	// ------------------------------------------------------------------------

	// One state byte, one element of GF(2^8)
	typedef logic [7:0] byte_t;

	// A column of the state or a key word
	// Element 0 is row 0 and sits in the most significant byte
	typedef byte_t [0:3] word_t;

	// Plaintext, ciphertext and round keys all use the flat 128-bit form
	typedef logic [127:0] block_t;

	// The state is read two ways over the same bits
	// As bytes in column-major order, byte index is 4 * column + row
	// As columns, which is the natural unit for MixColumns and the key XOR
	// Byte 0 is the first byte of the block as written in the test vectors
	typedef union packed {
		byte_t [0:15] bytes;
		word_t [0:3] cols;
	} aesState_t;

endpackage

// File: keyIf.sv
`timescale 1ns/1ns

// Round sequencing strobes plus the key that goes with them
// The key is valid in the same cycle as load or step
interface keyIf import aesTypesPkg::*; ();

	logic load;       // Start accepted, key is the cipher key
	logic step;       // One round is applied at the next edge
	logic lastRound;  // The step in flight is round ten
	block_t roundKey;

	modport ctrl (
		output load,
		output step,
		output lastRound
	);

	modport sched (
		input load,
		input step,
		output roundKey
	);

	modport dp (
		input load,
		input step,
		input lastRound,
		input roundKey
	);

endinterface

// File: verilog.f
aesTypesPkg.sv
aesGfPkg.sv
keyIf.sv
aesMixColumns.sv
aesControl.sv
aesKeySchedule.sv
aesRoundDatapath.sv
aesCore.sv
aesCore_asserts.sv
aesCoreTb.sv
